/* verilog/lsq_cfg.svh */
// Queue geometry and bus widths for the load/store queue, included by each LSQ source
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// ==========================================================================
// Queue geometry
// ==========================================================================
// Each row holds two entries, one per column, so four rows give eight entries
`define LSQ_ROWS 4
`define LSQ_ENTRIES (`LSQ_ROWS * 2)

// ==========================================================================
// Address and data widths
// ==========================================================================
// Byte address, wide enough for the whole data memory
`define ADR_W 10
`define DATA_W 32
// Depth of the data memory in 32-bit words
`define MEM_WORDS 256
// Lowest address bit that the overlap compare looks at (16-byte lines)
`define LSQ_LINE_LSB 4

`endif

/* verilog/lsq_pkg.sv */
// Shared entry, index and sequence-number types, imported by the LSQ modules
`default_nettype none
`include "lsq_cfg.svh"

package lsq_pkg;

	localparam int ROW_W = $clog2(`LSQ_ROWS);
	localparam int SN_W = 4;

	// Sequence number, one wider than the slot index so that age wraps cleanly
	typedef logic [SN_W-1:0] sn_t;

	// Row and column of one entry
	typedef struct packed {
		logic [ROW_W-1:0] row;
		logic col;
	} lsq_ndx_t;

	typedef struct packed {
		logic valid;
		logic is_store;
		logic agen;
		logic issued;
		logic done;
		sn_t sn;
		logic [`ADR_W-1:0] padr;
		logic [`DATA_W-1:0] data;
	} lsq_entry_t;

	typedef lsq_entry_t [`LSQ_ROWS-1:0][1:0] lsq_entries_t;

	// The slot of a sequence number is its value modulo eight
	// Bit 0 picks the column and the bits above it pick the row
	function automatic lsq_ndx_t sn_ndx(input sn_t sn);
		lsq_ndx_t ndx;
		ndx.row = sn[ROW_W:1];
		ndx.col = sn[0];
		return ndx;
	endfunction

	// Age relative to the head, so that the head entry is age zero
	function automatic sn_t sn_age(input sn_t sn, input sn_t head);
		return sn - head;
	endfunction

endpackage

`default_nettype wire

/* verilog/lsq_queue.sv */
// Entry ring of the load/store queue, with allocation, address fill, issue and retirement
`default_nettype none
`include "lsq_cfg.svh"

module lsq_queue (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic alloc,
	input wire logic alloc_is_store,
	input wire logic agen,
	input wire lsq_pkg::sn_t agen_sn,
	input wire logic [`ADR_W-1:0] agen_adr,
	input wire logic [`DATA_W-1:0] agen_data,
	input wire logic issue_strobe,
	input wire lsq_pkg::lsq_ndx_t issue_id,
	input wire logic mem_done_strobe,
	input wire lsq_pkg::lsq_ndx_t mem_done_id,
	output lsq_pkg::sn_t alloc_sn,
	output logic full,
	output lsq_pkg::sn_t head_sn,
	output lsq_pkg::lsq_entries_t entries
);
	import lsq_pkg::*;

	sn_t tail_sn;
	sn_t count;
	lsq_ndx_t tail_ndx;
	lsq_ndx_t head_ndx;
	lsq_ndx_t agen_ndx;
	logic alloc_ok;
	logic retire;

	// The ring is addressed purely by sequence number
	assign tail_ndx = sn_ndx(tail_sn);
	assign head_ndx = sn_ndx(head_sn);
	assign agen_ndx = sn_ndx(agen_sn);

	// Occupancy fits in the sequence number since it is one bit wider than the slot
	assign count = tail_sn - head_sn;
	assign full = (count == sn_t'(`LSQ_ENTRIES));
	assign alloc_ok = alloc && !full;
	// The next sequence number goes out with the strobe that takes it
	assign alloc_sn = tail_sn;

	// Head leaves one cycle after its done flag shows
	assign retire = entries[head_ndx.row][head_ndx.col].valid &&
		entries[head_ndx.row][head_ndx.col].done;

	// ==========================================================================
	// Entry state
	// ==========================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_sn <= '0;
			tail_sn <= '0;
			for (int r = 0; r < `LSQ_ROWS; r++) begin
				for (int c = 0; c < 2; c++) begin
					entries[r][c].valid <= 1'b0;
					entries[r][c].agen <= 1'b0;
					entries[r][c].issued <= 1'b0;
					entries[r][c].done <= 1'b0;
				end
			end
		end else begin
			// New entry at the tail, waiting for its address
			if (alloc_ok) begin
				entries[tail_ndx.row][tail_ndx.col].valid <= 1'b1;
				entries[tail_ndx.row][tail_ndx.col].is_store <= alloc_is_store;
				entries[tail_ndx.row][tail_ndx.col].agen <= 1'b0;
				entries[tail_ndx.row][tail_ndx.col].issued <= 1'b0;
				entries[tail_ndx.row][tail_ndx.col].done <= 1'b0;
				entries[tail_ndx.row][tail_ndx.col].sn <= tail_sn;
				tail_sn <= tail_sn + 1'b1;
			end
			// Address and store data arrive in any order
			if (agen) begin
				entries[agen_ndx.row][agen_ndx.col].agen <= 1'b1;
				entries[agen_ndx.row][agen_ndx.col].padr <= agen_adr;
				entries[agen_ndx.row][agen_ndx.col].data <= agen_data;
			end
			// Issued at grant, so the lane moves on to its next entry
			if (issue_strobe)
				entries[issue_id.row][issue_id.col].issued <= 1'b1;
			// done follows the memory access one cycle after the grant
			if (mem_done_strobe)
				entries[mem_done_id.row][mem_done_id.col].done <= 1'b1;
			if (retire) begin
				entries[head_ndx.row][head_ndx.col].valid <= 1'b0;
				head_sn <= head_sn + 1'b1;
			end
		end
	end

	// ==========================================================================
	// Client protocol checks
	// ==========================================================================
	// An address may only be given once, to an entry between head and tail
	a_agen_target: assert property (@(posedge clk) disable iff (!rst_n)
		agen |-> (sn_age(agen_sn, head_sn) < count) &&
			!entries[agen_ndx.row][agen_ndx.col].agen);

	// A taken allocation never lands on a slot that is still live
	a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
		alloc_ok |-> !entries[tail_ndx.row][tail_ndx.col].valid);

endmodule

`default_nettype wire

/* verilog/lsq_overlap_check.sv */
// Combinational memory-disambiguation check of one candidate against all older entries
`default_nettype none
`include "lsq_cfg.svh"

module lsq_overlap_check (
	input wire lsq_pkg::lsq_entries_t entries,
	input wire lsq_pkg::sn_t head_sn,
	input wire lsq_pkg::lsq_ndx_t cand_id,
	output logic has_overlap
);
	import lsq_pkg::*;

	lsq_entry_t cand;
	sn_t cand_age;

	assign cand = entries[cand_id.row][cand_id.col];
	assign cand_age = sn_age(cand.sn, head_sn);

	// ==========================================================================
	// Scan of every slot
	// ==========================================================================
	// Only older entries matter, and only while they have not finished
	// An entry without an address may touch anything, so it always blocks
	// Two loads to the same line are harmless, any store in the pair is not
	always_comb begin
		lsq_entry_t e;
		has_overlap = 1'b0;
		for (int r = 0; r < `LSQ_ROWS; r++) begin
			for (int c = 0; c < 2; c++) begin
				e = entries[r][c];
				if (e.valid && !e.done && (sn_age(e.sn, head_sn) < cand_age)) begin
					if (!e.agen) begin
						has_overlap = 1'b1;
					end else if ((e.padr[`ADR_W-1:`LSQ_LINE_LSB] ==
							cand.padr[`ADR_W-1:`LSQ_LINE_LSB]) &&
							(e.is_store || cand.is_store)) begin
						has_overlap = 1'b1;
					end
				end
			end
		end
	end

	// The candidate is never compared with itself since its own age is not less

endmodule

`default_nettype wire

/* verilog/lsq_issue_lane.sv */
// Issue lane for one queue column, picks the oldest ready entry and holds it until granted
`default_nettype none
`include "lsq_cfg.svh"

module lsq_issue_lane #(
	parameter bit COL = 1'b0
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire lsq_pkg::lsq_entries_t entries,
	input wire lsq_pkg::sn_t head_sn,
	input wire logic has_overlap,
	input wire logic gnt,
	output lsq_pkg::lsq_ndx_t cand_id,
	output logic req,
	output logic [`ADR_W-1:0] req_adr,
	output logic [`DATA_W-1:0] req_data,
	output logic req_we,
	output lsq_pkg::lsq_ndx_t req_id
);
	import lsq_pkg::*;

	logic cand_valid;
	sn_t best_age;
	lsq_entry_t cand;

	// ==========================================================================
	// Candidate selection
	// ==========================================================================
	// Oldest entry of this column that has an address and has not issued
	always_comb begin
		cand_valid = 1'b0;
		cand_id = '{row: '0, col: COL};
		best_age = '0;
		for (int r = 0; r < `LSQ_ROWS; r++) begin
			if (entries[r][COL].valid && entries[r][COL].agen && !entries[r][COL].issued &&
					(!cand_valid || sn_age(entries[r][COL].sn, head_sn) < best_age)) begin
				cand_valid = 1'b1;
				cand_id.row = ROW_W'(r);
				best_age = sn_age(entries[r][COL].sn, head_sn);
			end
		end
	end

	assign cand = entries[cand_id.row][cand_id.col];

	// ==========================================================================
	// Held request
	// ==========================================================================
	// After a grant the lane idles one cycle, which lets the issued flag land
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req <= 1'b0;
		end else if (req) begin
			if (gnt)
				req <= 1'b0;
		end else if (cand_valid && !has_overlap) begin
			req <= 1'b1;
		end
	end

	// Payload follows the candidate while idle and freezes under req
	always_ff @(posedge clk) begin
		if (!req) begin
			req_adr <= cand.padr;
			req_data <= cand.data;
			req_we <= cand.is_store;
			req_id <= cand_id;
		end
	end

	// A held request keeps pointing at a live entry that has not issued yet
	a_req_live: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> entries[req_id.row][req_id.col].valid &&
			!entries[req_id.row][req_id.col].issued &&
			(entries[req_id.row][req_id.col].padr == req_adr));

endmodule

`default_nettype wire

/* verilog/lsq_mem_arbiter.sv */
// Round-robin arbiter between the two issue lanes for the single data memory port
`default_nettype none
`include "lsq_cfg.svh"

module lsq_mem_arbiter (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic req0,
	input wire logic req1,
	input wire logic [`ADR_W-1:0] req0_adr,
	input wire logic [`ADR_W-1:0] req1_adr,
	input wire logic [`DATA_W-1:0] req0_data,
	input wire logic [`DATA_W-1:0] req1_data,
	input wire logic req0_we,
	input wire logic req1_we,
	input wire lsq_pkg::lsq_ndx_t req0_id,
	input wire lsq_pkg::lsq_ndx_t req1_id,
	output logic [1:0] gnt,
	output logic mem_en,
	output logic mem_we,
	output logic [$clog2(`MEM_WORDS)-1:0] mem_adr,
	output logic [`DATA_W-1:0] mem_wdata,
	output logic issue_strobe,
	output lsq_pkg::lsq_ndx_t issue_id,
	output logic mem_done_strobe,
	output lsq_pkg::lsq_ndx_t mem_done_id
);
	localparam int WA_W = $clog2(`MEM_WORDS);

	// Lane that wins when both ask
	logic prio;

	always_comb begin
		if (req0 && req1)
			gnt = prio ? 2'b10 : 2'b01;
		else
			gnt = {req1, req0};
	end

	// The granted lane drives the memory in the same cycle
	assign mem_en = |gnt;
	assign mem_we = gnt[1] ? req1_we : req0_we;
	assign mem_adr = gnt[1] ? req1_adr[WA_W+1:2] : req0_adr[WA_W+1:2];
	assign mem_wdata = gnt[1] ? req1_data : req0_data;
	assign issue_strobe = |gnt;
	assign issue_id = gnt[1] ? req1_id : req0_id;

	// Loser of a contested cycle gets priority next
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prio <= 1'b0;
			mem_done_strobe <= 1'b0;
		end else begin
			if (gnt[0])
				prio <= 1'b1;
			else if (gnt[1])
				prio <= 1'b0;
			mem_done_strobe <= |gnt;
		end
	end

	// Completion lines up with the registered read data
	always_ff @(posedge clk) begin
		mem_done_id <= issue_id;
	end

	// A lane that loses keeps asking and is served on the very next cycle
	a_rr_lane0: assert property (@(posedge clk) disable iff (!rst_n)
		req0 && !gnt[0] |=> gnt[0]);
	a_rr_lane1: assert property (@(posedge clk) disable iff (!rst_n)
		req1 && !gnt[1] |=> gnt[1]);

endmodule

`default_nettype wire

/* verilog/lsq_data_mem.sv */
// Single-port word memory behind the arbiter, read data returns one cycle after enable
`default_nettype none
`include "lsq_cfg.svh"

module lsq_data_mem (
	input wire logic clk,
	input wire logic en,
	input wire logic we,
	input wire logic [$clog2(`MEM_WORDS)-1:0] adr,
	input wire logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W-1:0] rdata
);
	// Word array, addressed without the two byte bits
	logic [`DATA_W-1:0] mem [`MEM_WORDS];

	// ==========================================================================
	// Port
	// ==========================================================================
	// A write leaves rdata holding the last read
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[adr] <= wdata;
			else
				rdata <= mem[adr];
		end
	end

endmodule

`default_nettype wire

/* verilog/lsq_top.sv */
// Top level of the load/store queue, ties the ring, both lanes, the arbiter and memory
`default_nettype none
`include "lsq_cfg.svh"

module lsq_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic alloc,
	input wire logic alloc_is_store,
	output lsq_pkg::sn_t alloc_sn,
	output logic full,
	input wire logic agen,
	input wire lsq_pkg::sn_t agen_sn,
	input wire logic [`ADR_W-1:0] agen_adr,
	input wire logic [`DATA_W-1:0] agen_data,
	output logic load_valid,
	output lsq_pkg::sn_t load_sn,
	output logic [`DATA_W-1:0] load_data
);
	import lsq_pkg::*;

	lsq_entries_t entries;
	sn_t head_sn;
	lsq_ndx_t cand_id [2];
	logic [1:0] has_overlap;
	logic [1:0] req;
	logic [`ADR_W-1:0] req_adr [2];
	logic [`DATA_W-1:0] req_data [2];
	logic [1:0] req_we;
	lsq_ndx_t req_id [2];
	logic [1:0] gnt;
	logic mem_en;
	logic mem_we;
	logic [$clog2(`MEM_WORDS)-1:0] mem_adr;
	logic [`DATA_W-1:0] mem_wdata;
	logic issue_strobe;
	lsq_ndx_t issue_id;
	logic mem_done_strobe;
	lsq_ndx_t mem_done_id;
	lsq_entry_t done_entry;

	lsq_queue u_queue (
		.clk(clk), .rst_n(rst_n),
		.alloc(alloc), .alloc_is_store(alloc_is_store),
		.agen(agen), .agen_sn(agen_sn), .agen_adr(agen_adr), .agen_data(agen_data),
		.issue_strobe(issue_strobe), .issue_id(issue_id),
		.mem_done_strobe(mem_done_strobe), .mem_done_id(mem_done_id),
		.alloc_sn(alloc_sn), .full(full), .head_sn(head_sn), .entries(entries)
	);

	// One lane and one checker per column
	for (genvar g = 0; g < 2; g++) begin : g_col
		lsq_issue_lane #(.COL(1'(g))) u_lane (
			.clk(clk), .rst_n(rst_n), .entries(entries), .head_sn(head_sn),
			.has_overlap(has_overlap[g]), .gnt(gnt[g]), .cand_id(cand_id[g]),
			.req(req[g]), .req_adr(req_adr[g]), .req_data(req_data[g]),
			.req_we(req_we[g]), .req_id(req_id[g])
		);
		lsq_overlap_check u_check (
			.entries(entries), .head_sn(head_sn), .cand_id(cand_id[g]),
			.has_overlap(has_overlap[g])
		);
	end

	lsq_mem_arbiter u_arb (
		.clk(clk), .rst_n(rst_n), .req0(req[0]), .req1(req[1]),
		.req0_adr(req_adr[0]), .req1_adr(req_adr[1]),
		.req0_data(req_data[0]), .req1_data(req_data[1]),
		.req0_we(req_we[0]), .req1_we(req_we[1]),
		.req0_id(req_id[0]), .req1_id(req_id[1]), .gnt(gnt),
		.mem_en(mem_en), .mem_we(mem_we), .mem_adr(mem_adr), .mem_wdata(mem_wdata),
		.issue_strobe(issue_strobe), .issue_id(issue_id),
		.mem_done_strobe(mem_done_strobe), .mem_done_id(mem_done_id)
	);

	lsq_data_mem u_mem (
		.clk(clk), .en(mem_en), .we(mem_we), .adr(mem_adr),
		.wdata(mem_wdata), .rdata(load_data)
	);

	// The finishing entry is still valid here, its done flag lands at the edge
	assign done_entry = entries[mem_done_id.row][mem_done_id.col];
	assign load_valid = mem_done_strobe && !done_entry.is_store;
	assign load_sn = done_entry.sn;

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
// Testbench clock and synchronous reset source, instantiated once by the LSQ testbench
`default_nettype none

module clk_gen #(
	parameter int PERIOD = 8
) (
	output logic clk,
	output logic rst_n
);
	// Free-running clock, first rising edge half a period in
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset is seen low at the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* verif/lsq_tb.sv */
// Self-checking testbench of the load/store queue, the simulation top compiled from list.f
`default_nettype none
`include "lsq_cfg.svh"

module lsq_tb;
	import lsq_pkg::*;

	localparam int PERIOD = 8;
	localparam int OPS_MAX = 512;
	// Operations over all tests, the refused allocation included
	localparam int N_OPS = 329;

	logic clk;
	logic rst_n;
	logic alloc;
	logic alloc_is_store;
	sn_t alloc_sn;
	logic full;
	logic agen;
	sn_t agen_sn;
	logic [`ADR_W-1:0] agen_adr;
	logic [`DATA_W-1:0] agen_data;
	logic load_valid;
	sn_t load_sn;
	logic [`DATA_W-1:0] load_data;

	// Program-order log, indexed by how many allocations were accepted before
	bit op_store [OPS_MAX];
	bit [`ADR_W-1:0] op_adr [OPS_MAX];
	bit [`DATA_W-1:0] op_data [OPS_MAX];
	int done_cnt [OPS_MAX];
	// At most eight entries are in flight, so a sequence number names one operation
	int sn_to_op [16];
	int pend [$];
	int n_alloc;
	int n_loads_alloc;
	int n_loads_done;
	int err_data;
	int err_proto;
	integer seed;

	clk_gen #(.PERIOD(PERIOD)) u_clk (.clk(clk), .rst_n(rst_n));

	lsq_top dut (
		.clk(clk), .rst_n(rst_n),
		.alloc(alloc), .alloc_is_store(alloc_is_store), .alloc_sn(alloc_sn), .full(full),
		.agen(agen), .agen_sn(agen_sn), .agen_adr(agen_adr), .agen_data(agen_data),
		.load_valid(load_valid), .load_sn(load_sn), .load_data(load_data)
	);

	// ==========================================================================
	// Reference model
	// ==========================================================================
	// Replays every older store in program order over a word memory
	// A word that no store has written yet reads as unknown
	function automatic logic [`DATA_W-1:0] ref_load(input int op);
		logic [`DATA_W-1:0] model [`MEM_WORDS];
		for (int w = 0; w < `MEM_WORDS; w++)
			model[w] = 'x;
		for (int i = 0; i < op; i++) begin
			if (op_store[i])
				model[op_adr[i] / 4] = op_data[i];
		end
		return model[op_adr[op] / 4];
	endfunction

	// Every load_valid is matched to its operation and compared
	always @(negedge clk) begin : compare
		int op;
		logic [`DATA_W-1:0] expected;
		if (rst_n === 1'b1 && load_valid === 1'b1) begin
			op = sn_to_op[load_sn];
			expected = ref_load(op);
			done_cnt[op]++;
			n_loads_done++;
			if (op_store[op]) begin
				$display("load_valid was reported for sn %0d, which is a store", load_sn);
				err_proto++;
			end else if (load_data !== expected) begin
				$display("Error at %0t: load_data = %h, expected %h (sn %0d)",
					$time, load_data, expected, load_sn);
				err_data++;
			end
		end
	end

	// Generous bound of forty cycles per operation
	initial begin
		#(N_OPS * 40 * PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", N_OPS * 40);
		$display("Closing counts: %0d data errors, %0d protocol errors", err_data, err_proto);
		$display("tests failed");
		$finish;
	end

	// ==========================================================================
	// Drivers
	// ==========================================================================
	task automatic expect_val(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Error at %0t: %s = %0d, expected %0d", $time, name, got, want);
			err_proto++;
		end
	endtask

	// One clock of stimulus; the operation staged at n_alloc is the one offered
	// Acceptance is judged from full while the strobe is held
	task automatic drive_cycle(input bit do_alloc, input bit do_agen, input int agen_op,
			output bit ok);
		@(posedge clk);
		alloc <= do_alloc;
		alloc_is_store <= op_store[n_alloc];
		agen <= do_agen;
		agen_sn <= sn_t'(agen_op);
		agen_adr <= op_adr[agen_op];
		agen_data <= op_data[agen_op];
		@(negedge clk);
		ok = do_alloc && !full;
		if (do_alloc)
			expect_val("alloc_sn", alloc_sn, n_alloc % 16);
		if (ok) begin
			sn_to_op[n_alloc % 16] = n_alloc;
			if (!op_store[n_alloc])
				n_loads_alloc++;
			n_alloc++;
		end
	endtask

	task automatic alloc_staged(input bit is_store, input bit [`ADR_W-1:0] adr,
			input bit [`DATA_W-1:0] data);
		bit ok;
		op_store[n_alloc] = is_store;
		op_adr[n_alloc] = adr;
		op_data[n_alloc] = data;
		drive_cycle(1'b1, 1'b0, 0, ok);
		if (!ok) begin
			$display("An allocation was refused although the queue had room");
			err_proto++;
		end
	endtask

	// Allocates staged operations up to last and gives addresses in random order
	task automatic run_ops(input int last);
		bit ok;
		bit do_alloc;
		bit do_agen;
		int pick;
		int agen_op;
		while (n_alloc < last || pend.size() > 0) begin
			do_alloc = (n_alloc < last) && ($random(seed) & 1);
			do_agen = (pend.size() > 0) && ($random(seed) & 1);
			agen_op = 0;
			if (do_agen) begin
				pick = $unsigned($random(seed)) % pend.size();
				agen_op = pend[pick];
				pend.delete(pick);
			end
			drive_cycle(do_alloc, do_agen, agen_op, ok);
			if (ok)
				pend.push_back(n_alloc - 1);
		end
		drive_cycle(1'b0, 1'b0, 0, ok);
	endtask

	// All loads back, then the head catches up with the tail
	task automatic wait_idle();
		while (n_loads_done != n_loads_alloc)
			@(posedge clk);
		while (dut.head_sn !== alloc_sn)
			@(negedge clk);
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial begin
		int first;
		int base;
		bit ok;
		seed = 50;
		alloc = 1'b0;
		alloc_is_store = 1'b0;
		agen = 1'b0;
		agen_sn = '0;
		agen_adr = '0;
		agen_data = '0;

		// Reset leaves an empty queue
		while (rst_n !== 1'b1)
			@(posedge clk);
		@(negedge clk);
		expect_val("full", full, 0);
		expect_val("load_valid", load_valid, 0);
		expect_val("alloc_sn", alloc_sn, 0);

		// Store then load of the same word
		alloc_staged(1'b1, 10'h080, 32'hc0de_0002);
		alloc_staged(1'b0, 10'h080, 32'h0);
		pend.push_back(n_alloc - 2);
		pend.push_back(n_alloc - 1);
		run_ops(n_alloc);
		wait_idle();

		// Every word of the window is written first, then a mixed stream follows
		first = n_alloc;
		for (int i = 0; i < 316; i++) begin
			op_store[first + i] = (i < 16) ? 1'b1 : ($random(seed) & 1);
			op_adr[first + i] = (i < 16) ? i * 4 : ($random(seed) & 15) * 4;
			op_data[first + i] = $random(seed);
		end
		run_ops(first + 316);
		wait_idle();

		// A store with no address holds back a younger load to another line
		alloc_staged(1'b1, 10'h100, 32'h5a5a_0004);
		alloc_staged(1'b0, 10'h010, 32'h0);
		pend.push_back(n_alloc - 1);
		run_ops(n_alloc);
		base = n_loads_done;
		repeat (20) @(posedge clk);
		if (n_loads_done != base) begin
			$display("A load completed ahead of an older store that had no address");
			err_proto++;
		end
		pend.push_back(n_alloc - 2);
		run_ops(n_alloc);
		wait_idle();

		// Eight entries without addresses fill the queue
		for (int i = 0; i < 8; i++)
			alloc_staged(i % 2 == 0, i * 8, 32'h0f0f_0000 + i);
		drive_cycle(1'b1, 1'b0, 0, ok);
		if (ok) begin
			$display("A ninth allocation was accepted while the queue was full");
			err_proto++;
		end
		drive_cycle(1'b0, 1'b0, 0, ok);
		expect_val("full", full, 1);
		expect_val("alloc_sn", alloc_sn, n_alloc % 16);
		for (int i = 8; i > 0; i--)
			pend.push_back(n_alloc - i);
		run_ops(n_alloc);
		wait_idle();

		for (int i = 0; i < n_alloc; i++) begin
			if (!op_store[i] && done_cnt[i] != 1) begin
				$display("Load operation %0d completed %0d times", i, done_cnt[i]);
				err_proto++;
			end
		end
		$display("Closing counts: %0d data errors, %0d protocol errors", err_data, err_proto);
		if (err_data + err_proto == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/lsq_pkg.sv
verilog/lsq_queue.sv
verilog/lsq_overlap_check.sv
verilog/lsq_issue_lane.sv
verilog/lsq_mem_arbiter.sv
verilog/lsq_data_mem.sv
verilog/lsq_top.sv
verif/clk_gen.sv
verif/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsq_pkg.sv
      - verilog/lsq_queue.sv
      - verilog/lsq_overlap_check.sv
      - verilog/lsq_issue_lane.sv
      - verilog/lsq_mem_arbiter.sv
      - verilog/lsq_data_mem.sv
      - verilog/lsq_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/clk_gen.sv
      - verif/lsq_tb.sv
